/* tb.f */
reflet_pkg.sv
reflet_bus_if.sv
reflet_reset_sync.sv
reflet_ram16.sv
reflet_uart.sv
reflet_peripheral.sv
reflet_16bit_controler.sv
reflet_sva.sv
tb_reflet.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_reflet
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF -- '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_reflet.sv */
`timescale 1ns/10ps

module tb_reflet import reflet_pkg::*; ();

    localparam int    clk_period = 100;
    localparam int    bit_clocks = 10;
    localparam int    mem_pairs  = 16;
    localparam addr_t park_addr  = 16'h7FFF;
    // rough cycle cost of init, memory, gpio, timer, both uart tests and reset
    localparam int    budget_cycles = 40 + mem_pairs * 10 + 80 + 150 + 3 * bit_clocks * 12 + 60;

    logic       clk;
    logic       rst_n;
    addr_t      bus_addr;
    word_t      bus_wdata;
    logic       bus_write_en;
    word_t      bus_rdata;
    word_t      gpi;
    word_t      gpo;
    logic       rx;
    logic       tx;
    logic [3:0] exti;
    int         checks;
    int         errors;
    int         tests;

    reflet_16bit_controler #(
        .clk_freq     (10000000),
        .baud_rate    (1000000),
        .enable_gpio  (1'b1),
        .enable_timer (1'b1),
        .enable_uart  (1'b1)
    ) reflet_16bit_controler_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_write_en (bus_write_en),
        .bus_rdata    (bus_rdata),
        .gpi          (gpi),
        .gpo          (gpo),
        .rx           (rx),
        .tx           (tx),
        .exti         (exti)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic addr_t periph_addr(input word_t off);
        return periph_base + off;
    endfunction

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t ns %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        $display("%s finished with %0d errors", name, errors - start_errors);
    endtask

    // write takes effect on the second edge, returns just after it
    task automatic bus_write(input addr_t a, input word_t d);
        @(posedge clk);
        bus_addr     <= a;
        bus_wdata    <= d;
        bus_write_en <= 1'b1;
        @(posedge clk);
        bus_write_en <= 1'b0;
        bus_addr     <= park_addr;
    endtask

    task automatic bus_read(input addr_t a, output word_t d);
        @(posedge clk);
        bus_addr     <= a;
        bus_write_en <= 1'b0;
        @(posedge clk);
        bus_addr <= park_addr;
        @(negedge clk);
        d = bus_rdata;
    endtask

    // samples tx at mid-bit, counted from the edge that started the frame
    task automatic decode_tx(output byte_t value, output logic start_bit, output logic stop_bit);
        value = '0;
        repeat (bit_clocks / 2) @(negedge clk);
        start_bit = tx;
        repeat (8) begin
            repeat (bit_clocks) @(negedge clk);
            value = {tx, value[7:1]};
        end
        repeat (bit_clocks) @(negedge clk);
        stop_bit = tx;
    endtask

    task automatic send_rx(input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        repeat (10) begin
            @(posedge clk);
            rx    <= frame[0];
            frame = frame >> 1;
            repeat (bit_clocks - 1) @(posedge clk);
        end
    endtask

    task automatic poll_status(input int bit_pos, input logic level, output logic seen);
        word_t got;
        seen = 1'b0;
        for (int i = 0; i < 20 && !seen; i++) begin
            bus_read(periph_addr(reg_uart_status), got);
            seen = ((got >> bit_pos) & 16'd1) == word_t'(level);
        end
    endtask

    task automatic test_memory();
        word_t model [addr_t];
        addr_t a;
        word_t d;
        word_t got;
        int    start_errors;
        start_errors = errors;
        for (int i = 0; i < mem_pairs; i++) begin
            a = addr_t'($urandom_range(127, 0));
            d = word_t'($urandom());
            bus_write(a, d);
            model[a] = d;
            a = 16'h8000 + addr_t'($urandom_range(99, 0));
            d = word_t'($urandom());
            bus_write(a, d);
            model[a] = d;
        end
        foreach (model[k]) begin
            bus_read(k, got);
            check_value($sformatf("mem[%h]", k), got, model[k]);
        end
        // past the end of each ram, and the gaps of the windows
        bus_write(16'h0080, 16'hDEAD);
        bus_read(16'h0080, got);
        check_value("inst ram above size", got, 16'h0000);
        bus_write(16'h8064, 16'hBEEF);
        bus_read(16'h8064, got);
        check_value("data ram above size", got, 16'h0000);
        bus_read(16'h7FFF, got);
        check_value("inst window gap", got, 16'h0000);
        bus_read(16'hFEFF, got);
        check_value("data window gap", got, 16'h0000);
        finish_test("memory round trip", start_errors);
    endtask

    task automatic test_gpio();
        word_t d;
        word_t got;
        int    start_errors;
        start_errors = errors;
        d = word_t'($urandom());
        bus_write(periph_addr(reg_gpo), d);
        @(negedge clk);
        check_value("gpo", gpo, d);
        bus_read(periph_addr(reg_gpo), got);
        check_value("gpo readback", got, d);
        d = word_t'($urandom()) & 16'hFFFE;
        @(posedge clk);
        gpi <= d;
        bus_read(periph_addr(reg_gpi), got);
        check_value("gpi readback", got, d);
        @(posedge clk);
        gpi <= d | 16'd1;
        @(posedge clk);
        @(negedge clk);
        check_value("exti gpi edge", word_t'(exti[exti_gpi_edge[1:0]]), 16'd1);
        bus_write(periph_addr(reg_exti), 16'd1 << exti_gpi_edge);
        @(negedge clk);
        check_value("exti gpi edge cleared", word_t'(exti[exti_gpi_edge[1:0]]), 16'd0);
        finish_test("gpio", start_errors);
    endtask

    task automatic test_timer();
        word_t p;
        word_t got;
        int    waited;
        logic  flag;
        int    start_errors;
        start_errors = errors;
        p = word_t'($urandom_range(12, 3));
        bus_write(periph_addr(reg_timer_period), p);
        waited = 0;
        flag   = 1'b0;
        while (!flag && waited < int'(p) + 2) begin
            @(negedge clk);
            waited++;
            flag = (exti[exti_timer[1:0]] === 1'b1);
        end
        if (!flag) begin
            report_error($sformatf("timer flag not set within %0d cycles", int'(p) + 2));
        end
        for (int i = 0; i < 2 * int'(p); i++) begin
            bus_read(periph_addr(reg_timer_count), got);
            check_value("timer count at most period", word_t'(got <= p), 16'd1);
        end
        // stop first so no wrap can set the flag again
        bus_write(periph_addr(reg_timer_period), 16'd0);
        bus_write(periph_addr(reg_exti), 16'd1 << exti_timer);
        bus_read(periph_addr(reg_exti), got);
        check_value("exti timer cleared", (got >> exti_timer) & 16'd1, 16'd0);
        finish_test("timer", start_errors);
    endtask

    task automatic test_uart_tx();
        byte_t b;
        byte_t seen_byte;
        logic  start_bit;
        logic  stop_bit;
        logic  idle_seen;
        word_t got;
        int    start_errors;
        start_errors = errors;
        b = byte_t'($urandom());
        bus_write(periph_addr(reg_uart_data), {8'h00, b});
        fork
            begin
                bus_read(periph_addr(reg_uart_status), got);
                check_value("tx_busy after write", (got >> 1) & 16'd1, 16'd1);
            end
            decode_tx(seen_byte, start_bit, stop_bit);
        join
        check_value("tx start bit", word_t'(start_bit), 16'd0);
        check_value("tx data byte", word_t'(seen_byte), word_t'(b));
        check_value("tx stop bit", word_t'(stop_bit), 16'd1);
        poll_status(1, 1'b0, idle_seen);
        if (!idle_seen) begin
            report_error("tx_busy did not clear after the stop bit");
        end
        finish_test("uart transmit", start_errors);
    endtask

    task automatic test_uart_rx();
        byte_t b;
        word_t got;
        logic  valid_seen;
        int    start_errors;
        start_errors = errors;
        b = byte_t'($urandom());
        send_rx(b);
        poll_status(0, 1'b1, valid_seen);
        if (!valid_seen) begin
            report_error("rx_valid did not rise after the stop bit");
        end
        @(negedge clk);
        check_value("exti uart rx", word_t'(exti[exti_uart_rx[1:0]]), 16'd1);
        bus_read(periph_addr(reg_uart_data), got);
        check_value("rx data", got, {8'h00, b});
        bus_read(periph_addr(reg_uart_status), got);
        check_value("rx_valid after read", got & 16'd1, 16'd0);
        bus_write(periph_addr(reg_exti), 16'd1 << exti_uart_rx);
        finish_test("uart receive", start_errors);
    endtask

    task automatic test_reset();
        word_t got;
        int    start_errors;
        start_errors = errors;
        bus_write(16'h0000, 16'hBEEF);
        bus_write(periph_addr(reg_gpo), word_t'($urandom()) | 16'd1);
        @(posedge clk);
        gpi <= 16'd0;
        @(posedge clk);
        gpi <= 16'd1;
        @(posedge clk);
        gpi <= 16'd0;
        @(negedge clk);
        check_value("exti before reset", word_t'(exti[exti_gpi_edge[1:0]]), 16'd1);
        // reset lands in the middle of a frame
        bus_write(periph_addr(reg_uart_data), 16'h0000);
        @(posedge clk);
        rst_n    <= 1'b0;
        bus_addr <= 16'h0000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("gpo in reset", gpo, 16'd0);
        check_value("exti in reset", word_t'(exti), 16'd0);
        check_value("bus_rdata in reset", bus_rdata, 16'd0);
        check_value("tx in reset", word_t'(tx), 16'd1);
        @(posedge clk);
        rst_n    <= 1'b1;
        bus_addr <= park_addr;
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_value("gpo after reset", gpo, 16'd0);
        check_value("exti after reset", word_t'(exti), 16'd0);
        check_value("tx after reset", word_t'(tx), 16'd1);
        bus_read(periph_addr(reg_gpo), got);
        check_value("gpo readback after reset", got, 16'd0);
        finish_test("reset", start_errors);
    endtask

    initial begin
        void'($urandom(68871));
        checks       = 0;
        errors       = 0;
        tests        = 0;
        rst_n        = 1'b0;
        bus_addr     = park_addr;
        bus_wdata    = '0;
        bus_write_en = 1'b0;
        gpi          = '0;
        rx           = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // internal reset holds for 4 more clocks
        repeat (6) @(posedge clk);
        test_memory();
        test_gpio();
        test_timer();
        test_uart_tx();
        test_uart_rx();
        test_reset();
        $display("tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(budget_cycles * 2 * clk_period);
        $display("timeout: the tests did not finish within %0d cycles", budget_cycles * 2);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* reflet_sva.sv */
`timescale 1ns/10ps

module reflet_sva import reflet_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       sys_rst_n,
    input addr_t      bus_addr,
    input logic       bus_write_en,
    input logic       tx_busy,
    input logic       tx,
    input word_t      bus_rdata,
    input logic [3:0] exti
);

    logic uart_write;

    // byte written to the uart data register
    assign uart_write = bus_write_en && (bus_addr == periph_base + reg_uart_data);

    // line stays at mark level while the transmitter is idle and no byte is written
    property tx_high_when_idle;
        @(posedge clk) disable iff (!sys_rst_n) !tx_busy && !uart_write |=> tx;
    endproperty

    // every slave clears its read register during internal reset
    property rdata_zero_after_reset;
        @(posedge clk) !sys_rst_n |=> (bus_rdata == '0);
    endproperty

    property exti_known;
        @(posedge clk) disable iff (!rst_n) !$isunknown(exti);
    endproperty

    assert property (tx_high_when_idle)
        else $error("tx is low while the uart transmitter is idle");
    assert property (rdata_zero_after_reset)
        else $error("bus_rdata is not zero one cycle after reset");
    assert property (exti_known)
        else $error("exti has unknown bits");

endmodule

bind reflet_16bit_controler reflet_sva sva_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .sys_rst_n    (sys_rst_n),
    .bus_addr     (bus_addr),
    .bus_write_en (bus_write_en),
    .tx_busy      (periph.uart_tx_busy),
    .tx           (tx),
    .bus_rdata    (bus_rdata),
    .exti         (exti)
);

/* reflet_16bit_controler.sv */
`timescale 1ns/10ps

module reflet_16bit_controler import reflet_pkg::*; #(
    parameter int clk_freq     = 1000000,
    parameter int baud_rate    = 9600,
    parameter bit enable_gpio  = 1'b1,
    parameter bit enable_timer = 1'b1,
    parameter bit enable_uart  = 1'b1
) (
    input  logic       clk,
    input  logic       rst_n,
    // bus master side
    input  addr_t      bus_addr,
    input  word_t      bus_wdata,
    input  logic       bus_write_en,
    output word_t      bus_rdata,
    // gpio
    input  word_t      gpi,
    output word_t      gpo,
    // uart
    input  logic       rx,
    output logic       tx,
    output logic [3:0] exti
);

    logic sys_rst_n;

    reflet_reset_sync reset_bootstrap (
        .clk       (clk),
        .rst_n     (rst_n),
        .reset_int (sys_rst_n)
    );

    reflet_bus_if inst_bus ();
    reflet_bus_if data_bus ();
    reflet_bus_if periph_bus ();

    // same request to every slave
    assign inst_bus.addr       = bus_addr;
    assign inst_bus.wdata      = bus_wdata;
    assign inst_bus.write_en   = bus_write_en;
    assign data_bus.addr       = bus_addr;
    assign data_bus.wdata      = bus_wdata;
    assign data_bus.write_en   = bus_write_en;
    assign periph_bus.addr     = bus_addr;
    assign periph_bus.wdata    = bus_wdata;
    assign periph_bus.write_en = bus_write_en;

    // slaves return zero outside their window
    assign bus_rdata = inst_bus.rdata | data_bus.rdata | periph_bus.rdata;

    // 0x0000 to 0x7FFF: instruction
    reflet_ram16 #(
        .base  (16'h0000),
        .size  (128),
        .limit (16'h8000)
    ) mem_inst (
        .clk   (clk),
        .rst_n (sys_rst_n),
        .bus   (inst_bus.slave)
    );

    // 0x8000 to 0xFEFF: data
    reflet_ram16 #(
        .base  (16'h8000),
        .size  (100),
        .limit (periph_base)
    ) mem_data (
        .clk   (clk),
        .rst_n (sys_rst_n),
        .bus   (data_bus.slave)
    );

    // 0xFF00 to 0xFFFF: peripherals
    reflet_peripheral #(
        .clk_freq     (clk_freq),
        .baud_rate    (baud_rate),
        .enable_gpio  (enable_gpio),
        .enable_timer (enable_timer),
        .enable_uart  (enable_uart)
    ) periph (
        .clk   (clk),
        .rst_n (sys_rst_n),
        .bus   (periph_bus.slave),
        .gpi   (gpi),
        .gpo   (gpo),
        .rx    (rx),
        .tx    (tx),
        .exti  (exti)
    );

endmodule

/* reflet_peripheral.sv */
`timescale 1ns/10ps

module reflet_peripheral import reflet_pkg::*; #(
    parameter int clk_freq     = 10000000,
    parameter int baud_rate    = 1000000,
    parameter bit enable_gpio  = 1'b1,
    parameter bit enable_timer = 1'b1,
    parameter bit enable_uart  = 1'b1
) (
    input  logic        clk,
    input  logic        rst_n,
    reflet_bus_if.slave bus,
    input  word_t       gpi,
    output word_t       gpo,
    input  logic        rx,
    output logic        tx,
    output logic [3:0]  exti
);

    addr_t      offset;
    logic       in_window;
    logic       wr;
    logic       rd_uart;
    word_t      timer_period;
    word_t      timer_count;
    logic       timer_wrap;
    byte_t      rx_buf;
    logic       rx_valid;
    logic       gpi_prev;
    logic [3:0] exti_set;
    word_t      rd_val;
    byte_t      uart_rx_data;
    logic       uart_rx_done;
    logic       uart_tx_busy;
    logic       uart_tx_start;

    assign in_window = (bus.addr >= periph_base);
    assign offset    = bus.addr - periph_base;
    assign wr        = in_window && bus.write_en;
    // no read strobe on this bus, any non-write access counts as a read
    assign rd_uart   = in_window && !bus.write_en && (offset == reg_uart_data);
    // writes while busy are dropped, master polls tx_busy
    assign uart_tx_start = wr && (offset == reg_uart_data) && !uart_tx_busy;
    assign timer_wrap    = enable_timer && (timer_period != '0) && (timer_count == timer_period);

    always_comb begin
        exti_set = '0;
        exti_set[exti_timer[1:0]]    = timer_wrap;
        exti_set[exti_uart_rx[1:0]]  = uart_rx_done;
        exti_set[exti_gpi_edge[1:0]] = enable_gpio && gpi[0] && !gpi_prev;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpo          <= '0;
            gpi_prev     <= 1'b0;
            timer_period <= '0;
            timer_count  <= '0;
            rx_buf       <= '0;
            rx_valid     <= 1'b0;
            exti         <= '0;
        end else begin
            gpi_prev <= gpi[0];
            if (enable_gpio && wr && (offset == reg_gpo)) begin
                gpo <= bus.wdata;
            end
            // period 0 keeps the timer stopped
            if (enable_timer && wr && (offset == reg_timer_period)) begin
                timer_period <= bus.wdata;
                timer_count  <= '0;
            end else if (timer_wrap) begin
                timer_count <= '0;
            end else if (timer_period != '0) begin
                timer_count <= timer_count + 16'd1;
            end
            if (uart_rx_done) begin
                rx_buf   <= uart_rx_data;
                rx_valid <= 1'b1;
            end else if (rd_uart) begin
                rx_valid <= 1'b0;
            end
            // write 1 to clear, a new event in the same cycle wins
            if (wr && (offset == reg_exti)) begin
                exti <= (exti & ~bus.wdata[3:0]) | exti_set;
            end else begin
                exti <= exti | exti_set;
            end
        end
    end

    always_comb begin
        rd_val = '0;
        if (in_window) begin
            case (offset)
                reg_gpi:          rd_val = enable_gpio ? gpi : '0;
                reg_gpo:          rd_val = enable_gpio ? gpo : '0;
                reg_uart_data:    rd_val = enable_uart ? {8'h00, rx_buf} : '0;
                reg_uart_status:  rd_val = enable_uart ? {14'h0, uart_tx_busy, rx_valid} : '0;
                reg_timer_period: rd_val = enable_timer ? timer_period : '0;
                reg_timer_count:  rd_val = enable_timer ? timer_count : '0;
                reg_exti:         rd_val = {12'h000, exti};
                default:          rd_val = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rdata <= '0;
        end else begin
            bus.rdata <= rd_val;
        end
    end

    generate
        if (enable_uart) begin : gen_uart
            reflet_uart #(
                .clk_freq  (clk_freq),
                .baud_rate (baud_rate)
            ) uart_inst (
                .clk      (clk),
                .rst_n    (rst_n),
                .tx_data  (bus.wdata[7:0]),
                .tx_start (uart_tx_start),
                .tx_busy  (uart_tx_busy),
                .rx_data  (uart_rx_data),
                .rx_done  (uart_rx_done),
                .rx       (rx),
                .tx       (tx)
            );
        end else begin : gen_no_uart
            // line held idle
            assign tx           = 1'b1;
            assign uart_tx_busy = 1'b0;
            assign uart_rx_done = 1'b0;
            assign uart_rx_data = '0;
        end
    endgenerate

endmodule

/* reflet_uart.sv */
`timescale 1ns/10ps

module reflet_uart import reflet_pkg::*; #(
    parameter int clk_freq  = 10000000,
    parameter int baud_rate = 1000000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t tx_data,
    input  logic  tx_start,
    output logic  tx_busy,
    output byte_t rx_data,
    output logic  rx_done,
    input  logic  rx,
    output logic  tx
);

    // clocks per bit and half of it for the start bit check
    localparam logic [15:0] bit_ticks  = 16'(clk_freq / baud_rate);
    localparam logic [15:0] half_ticks = bit_ticks >> 1;

    uart_state_t tx_state;
    logic [15:0] tx_cnt;
    logic [2:0]  tx_bit;
    byte_t       tx_shift;
    logic        tx_end;

    uart_state_t rx_state;
    logic [15:0] rx_cnt;
    logic [2:0]  rx_bit;
    byte_t       rx_shift;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_end;

    assign tx_end  = (tx_cnt == bit_ticks - 16'd1);
    assign rx_end  = (rx_cnt == bit_ticks - 16'd1);
    assign tx_busy = (tx_state != idle);
    assign rx_data = rx_shift;

    // line level follows the transmit state, lsb first
    assign tx = (tx_state == start) ? 1'b0 :
                (tx_state == data)  ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= idle;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx_shift <= '0;
        end else if (tx_state == idle) begin
            tx_cnt <= '0;
            tx_bit <= '0;
            if (tx_start) begin
                tx_shift <= tx_data;
                tx_state <= start;
            end
        end else if (tx_end) begin
            tx_cnt <= '0;
            case (tx_state)
                start: tx_state <= data;
                data: begin
                    tx_shift <= tx_shift >> 1;
                    tx_bit   <= tx_bit + 3'd1;
                    if (tx_bit == 3'd7) begin
                        tx_state <= stop;
                    end
                end
                default: tx_state <= idle;
            endcase
        end else begin
            tx_cnt <= tx_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state <= idle;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_shift <= '0;
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_done  <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_done <= 1'b0;
            case (rx_state)
                idle: begin
                    rx_cnt <= '0;
                    rx_bit <= '0;
                    if (!rx_sync) begin
                        rx_state <= start;
                    end
                end
                start: begin
                    // glitch filter: start bit must still be low at mid-bit
                    if (rx_cnt == half_ticks - 16'd1) begin
                        rx_cnt   <= '0;
                        rx_state <= rx_sync ? idle : data;
                    end else begin
                        rx_cnt <= rx_cnt + 16'd1;
                    end
                end
                data: begin
                    if (rx_end) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_sync, rx_shift[7:1]};
                        rx_bit   <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= stop;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 16'd1;
                    end
                end
                default: begin
                    // framing error drops the byte
                    if (rx_end) begin
                        rx_cnt   <= '0;
                        rx_done  <= rx_sync;
                        rx_state <= idle;
                    end else begin
                        rx_cnt <= rx_cnt + 16'd1;
                    end
                end
            endcase
        end
    end

endmodule

/* reflet_ram16.sv */
`timescale 1ns/10ps

module reflet_ram16 import reflet_pkg::*; #(
    parameter addr_t base  = 16'h0000,
    parameter int    size  = 128,
    parameter addr_t limit = 16'h8000
) (
    input  logic        clk,
    input  logic        rst_n,
    reflet_bus_if.slave bus
);

    localparam int idx_w = $clog2(size);

    word_t            mem [size];
    addr_t            offset;
    logic             in_window;
    logic             hit;
    logic [idx_w-1:0] idx;

    // window decode, then the part of the window that is backed by words
    assign offset    = bus.addr - base;
    assign in_window = (bus.addr >= base) && (bus.addr < limit);
    assign hit       = in_window && (offset < addr_t'(size));
    assign idx       = offset[idx_w-1:0];

    always_ff @(posedge clk) begin
        if (hit && bus.write_en) begin
            mem[idx] <= bus.wdata;
        end
    end

    // one cycle read latency, zero when not addressed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rdata <= '0;
        end else begin
            bus.rdata <= hit ? mem[idx] : '0;
        end
    end

endmodule

/* reflet_reset_sync.sv */
`timescale 1ns/10ps

module reflet_reset_sync (
    input  logic clk,
    input  logic rst_n,
    output logic reset_int
);

    logic [2:0] stretch_cnt;

    // asserts with rst_n, releases on the 4th clock after it rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stretch_cnt <= '0;
            reset_int   <= 1'b0;
        end else begin
            if (stretch_cnt != 3'd4) begin
                stretch_cnt <= stretch_cnt + 3'd1;
            end
            reset_int <= (stretch_cnt >= 3'd3);
        end
    end

endmodule

/* reflet_bus_if.sv */
`timescale 1ns/10ps

interface reflet_bus_if import reflet_pkg::*; ();

    addr_t addr;
    word_t wdata;
    logic  write_en;
    // driven by the slave, zero outside its window
    word_t rdata;

    modport master (
        output addr, wdata, write_en,
        input  rdata
    );

    modport slave (
        input  addr, wdata, write_en,
        output rdata
    );

endinterface

/* reflet_pkg.sv */
package reflet_pkg;

    // bus and character widths
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;

    // start of the peripheral window, top 256 words of the map
    localparam addr_t periph_base = 16'hFF00;

    // peripheral register offsets inside the window
    localparam word_t reg_gpi          = 16'd0;
    localparam word_t reg_gpo          = 16'd1;
    localparam word_t reg_uart_data    = 16'd2;
    localparam word_t reg_uart_status  = 16'd3;
    localparam word_t reg_timer_period = 16'd4;
    localparam word_t reg_timer_count  = 16'd5;
    localparam word_t reg_exti         = 16'd6;

    // bit positions in the exti flag word
    localparam word_t exti_timer    = 16'd0;
    localparam word_t exti_uart_rx  = 16'd1;
    localparam word_t exti_gpi_edge = 16'd2;

    // shared by the uart transmit and receive fsms
    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } uart_state_t;

endpackage
